//--- Makefile
SIM  := obj_dir/VknightTourTb
SRCS := $(filter-out +incdir+%,$(shell cat knightTour.f)) knight_settings.svh

.PHONY: all run clean

all: run

# Rebuild only when a source or the file list changes
$(SIM): $(SRCS) knightTour.f
	verilator --binary --timing --timescale 1ns/100ps -f knightTour.f --top-module knightTourTb

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

//--- cmdProc.sv
`timescale 1ns/100ps
`default_nettype none
`include "knight_settings.svh"

module cmdProc (
  input  logic                      clk,
  input  logic                      rstN,
  input  knightCmdPkg::knightCmd_t  cmd,
  input  logic                      cmdRdy,
  input  logic                      lineCross,
  output knightDrivePkg::driveReq_t driveReq,
  output logic                      calibrating,
  output knightCmdPkg::knightResp_e respByte,
  output logic                      respSend
);

  // Timer reloads, counting down to zero inclusive
  localparam logic [15:0] calLoad    = 16'(`KNIGHT_CAL_CYCLES - 1);
  localparam logic [15:0] settleLoad = 16'(`KNIGHT_SETTLE_CYCLES - 1);

  knightDrivePkg::procState_e state;
  logic [15:0]                timer;
  logic [3:0]                 squaresLeft;
  logic [7:0]                 heading;

  //////////////////////////////
  // Control FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state       <= knightDrivePkg::IDLE;
      timer       <= '0;
      squaresLeft <= '0;
      heading     <= 8'h00;
      respByte    <= knightCmdPkg::POS_ACK;
    end else begin
      case (state)
        knightDrivePkg::IDLE: begin
          // Commands only land here, anything else is dropped
          if (cmdRdy) begin
            case (cmd.opcode)
              knightCmdPkg::CAL_GYRO: begin
                state    <= knightDrivePkg::CALIBRATE;
                timer    <= calLoad;
                respByte <= knightCmdPkg::POS_ACK;
              end
              knightCmdPkg::MOVE: begin
                // New heading is presented right away
                state       <= knightDrivePkg::SETTLE;
                timer       <= settleLoad;
                heading     <= cmd.heading;
                squaresLeft <= cmd.squares;
                respByte    <= knightCmdPkg::POS_ACK;
              end
              default: begin
                state    <= knightDrivePkg::RESPOND;
                respByte <= knightCmdPkg::NEG_ACK;
              end
            endcase
          end
        end

        knightDrivePkg::CALIBRATE: begin
          timer <= timer - 16'd1;
          if (timer == '0)
            state <= knightDrivePkg::RESPOND;
        end

        knightDrivePkg::SETTLE: begin
          timer <= timer - 16'd1;
          // Zero squares means heading change only
          if (timer == '0)
            state <= (squaresLeft == '0) ? knightDrivePkg::RESPOND
                                         : knightDrivePkg::DRIVE;
        end

        knightDrivePkg::DRIVE: begin
          // One strobe per board line crossed
          if (lineCross) begin
            squaresLeft <= squaresLeft - 4'd1;
            if (squaresLeft == 4'd1)
              state <= knightDrivePkg::RESPOND;
          end
        end

        default: begin
          // RESPOND lasts exactly one cycle
          state <= knightDrivePkg::IDLE;
        end
      endcase
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  // Decoded straight from the state so edges line up with transitions
  always_comb begin
    driveReq.heading = heading;
    driveReq.moving  = (state == knightDrivePkg::DRIVE);
  end

  assign calibrating = (state == knightDrivePkg::CALIBRATE);
  assign respSend    = (state == knightDrivePkg::RESPOND);

endmodule

`default_nettype wire

//--- knightCmdPkg.sv
`default_nettype none

package knightCmdPkg;

  //////////////////////////////
  // Remote opcodes
  //////////////////////////////

  // Upper nibble of the 16-bit host command
  // Codes not listed here are answered with a negative acknowledge
  typedef enum logic [3:0] {
    CAL_GYRO = 4'h2,
    MOVE     = 4'h4
  } knightOp_e;

  //////////////////////////////
  // Command word
  //////////////////////////////

  // High byte arrives first, so opcode sits in the top bits
  // Heading: 0x00 north, 0x3F west, 0x7F south, 0xBF east
  typedef struct packed {
    knightOp_e   opcode;
    logic [7:0]  heading;
    logic [3:0]  squares;
  } knightCmd_t;

  //////////////////////////////
  // Response byte
  //////////////////////////////

  // One byte returned per command
  typedef enum logic [7:0] {
    POS_ACK = 8'hA5,
    NEG_ACK = 8'h5A
  } knightResp_e;

endpackage

`default_nettype wire

//--- knightDrivePkg.sv
`default_nettype none

package knightDrivePkg;

  //////////////////////////////
  // Drive request
  //////////////////////////////

  // Stands in for the motor side
  // Heading to hold, and whether to drive forward
  typedef struct packed {
    logic [7:0] heading;
    logic       moving;
  } driveReq_t;

  //////////////////////////////
  // Controller states
  //////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    CALIBRATE,
    SETTLE,
    DRIVE,
    RESPOND
  } procState_e;

endpackage

`default_nettype wire

//--- knightTour.f
+incdir+.
knightCmdPkg.sv
knightDrivePkg.sv
uartRx.sv
uartTx.sv
remoteLink.sv
cmdProc.sv
knightTour.sv
knightTourTb.sv

//--- knightTour.sv
`timescale 1ns/100ps
`default_nettype none

module knightTour (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      rx,
  output logic                      tx,
  input  logic                      lineCross,
  output knightDrivePkg::driveReq_t driveReq,
  output logic                      calibrating
);

  // Serial side
  logic [7:0] rxByte, txByte;
  logic       rxByteRdy, txStart, txBusy;

  // Command side
  knightCmdPkg::knightCmd_t  cmd;
  logic                      cmdRdy;
  knightCmdPkg::knightResp_e respByte;
  logic                      respSend;

  //////////////////////////////
  // Host link
  //////////////////////////////

  uartRx iRx (.clk(clk), .rstN(rstN), .rx(rx), .rxByte(rxByte), .rxByteRdy(rxByteRdy));

  uartTx iTx (.clk(clk), .rstN(rstN), .txStart(txStart), .txByte(txByte),
              .tx(tx), .txBusy(txBusy));

  remoteLink iLink (.clk(clk), .rstN(rstN), .rxByte(rxByte), .rxByteRdy(rxByteRdy),
                    .cmd(cmd), .cmdRdy(cmdRdy), .respByte(respByte), .respSend(respSend),
                    .txByte(txByte), .txStart(txStart), .txBusy(txBusy));

  //////////////////////////////
  // Command processor
  //////////////////////////////

  cmdProc iProc (.clk(clk), .rstN(rstN), .cmd(cmd), .cmdRdy(cmdRdy),
                 .lineCross(lineCross), .driveReq(driveReq), .calibrating(calibrating),
                 .respByte(respByte), .respSend(respSend));

endmodule

`default_nettype wire

//--- knightTourTb.sv
`timescale 1ns/100ps
`default_nettype none
`include "knight_settings.svh"

module knightTourTb;

  localparam int frameCycles  = 10 * `KNIGHT_BAUD_DIV;
  localparam int moveTests    = 8;
  localparam int unknownTests = 4;
  // Reset, calibrate, zero squares and busy plus the random ones
  localparam int numTests     = 4 + moveTests + unknownTests;
  // Up to 7 idle cycles, then the strobe and its low cycle
  localparam int maxSpacing   = 9;
  localparam int worstTest    = 6 * frameCycles + `KNIGHT_CAL_CYCLES + `KNIGHT_SETTLE_CYCLES
                                + 15 * maxSpacing;
  localparam int cycleLimit   = numTests * worstTest + 2000;
  localparam int respWait     = 3 * frameCycles + `KNIGHT_CAL_CYCLES + `KNIGHT_SETTLE_CYCLES;

  logic                      clk, rstN, rx, tx, lineCross, calibrating;
  knightDrivePkg::driveReq_t driveReq;

  logic [15:0] lfsr;
  logic [7:0]  respQ[$];
  logic [7:0]  expHeading;
  int          mismatches, failures, frameErrors;

  // Observer state is written only at the falling edge
  int          cycle, calCount, movingCount, riseCycle, headCycle, txFallCycle;
  logic        prevMoving, prevTx;
  logic [7:0]  prevHeading;

  knightTour u_dut (.clk(clk), .rstN(rstN), .rx(rx), .tx(tx), .lineCross(lineCross),
                    .driveReq(driveReq), .calibrating(calibrating));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // Random numbers and model
  //////////////////////////////

  // Fibonacci LFSR with taps 16 14 13 11 and one step per bit taken
  function automatic logic [15:0] randBits(input int n);
    logic [15:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[14:0], fb};
    end
    return v;
  endfunction

  // Calibrate and move are known and all else gets the negative ack
  function automatic logic [7:0] expectResp(input logic [3:0] op);
    return (op == 4'h2 || op == 4'h4) ? 8'hA5 : 8'h5A;
  endfunction

  function automatic logic willMove(input logic [3:0] op, input logic [3:0] squares);
    return op == 4'h4 && squares != 4'd0;
  endfunction

  task automatic reportMismatch(input string name, input int exp, input int act);
    mismatches++;
    $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, exp, act);
  endtask

  //////////////////////////////
  // Observer and cycle limit
  //////////////////////////////

  always @(negedge clk) begin
    cycle++;
    if (!rstN) begin
      prevMoving  = 1'b0;
      prevHeading = 8'h00;
      prevTx      = 1'b1;
    end else begin
      if (calibrating)
        calCount++;
      if (driveReq.moving) begin
        movingCount++;
        if (!prevMoving)
          riseCycle = cycle;
      end
      // New heading marks entry into settle
      if (driveReq.heading != prevHeading)
        headCycle = cycle;
      // Start bit of a response frame, not a falling data bit inside one
      if (prevTx && !tx && cycle - txFallCycle >= frameCycles)
        txFallCycle = cycle;
      prevMoving  = driveReq.moving;
      prevHeading = driveReq.heading;
      prevTx      = tx;
    end
    if (cycle > cycleLimit) begin
      $display("Timeout after %0d cycles, the run did not finish", cycle);
      $display("Finished with errors");
      $finish;
    end
  end

  // Response decoder on tx that samples mid-bit at the falling edge
  initial begin : txMonitor
    logic [7:0] b;
    int         i;
    forever begin
      @(negedge clk);
      if (rstN === 1'b1 && tx === 1'b0) begin
        repeat (`KNIGHT_BAUD_DIV / 2) @(negedge clk);
        for (i = 0; i < 8; i++) begin
          repeat (`KNIGHT_BAUD_DIV) @(negedge clk);
          b[i] = tx;
        end
        repeat (`KNIGHT_BAUD_DIV) @(negedge clk);
        if (tx !== 1'b1) begin
          frameErrors++;
          $display("Response frame on tx ended without a stop bit");
        end else
          respQ.push_back(b);
      end
    end
  end

  //////////////////////////////
  // Host and sensor drivers
  //////////////////////////////

  // 8N1 frame sent LSB first with each bit held for one baud period
  task automatic sendByte(input logic [7:0] b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= frame[i];
      repeat (`KNIGHT_BAUD_DIV - 1) @(posedge clk);
    end
  endtask

  // High byte first
  task automatic sendCmd(input logic [15:0] word);
    sendByte(word[15:8]);
    sendByte(word[7:0]);
  endtask

  // Strobes during settle that the controller must ignore
  task automatic strays(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      repeat (int'(randBits(2))) @(posedge clk);
      @(posedge clk);
      lineCross <= 1'b1;
      @(posedge clk);
      lineCross <= 1'b0;
    end
  endtask

  // Moving must hold until the last strobe and fall right after it
  task automatic strobeLines(input string name, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      repeat (int'(randBits(3))) @(posedge clk);
      @(negedge clk);
      if (driveReq.moving !== 1'b1)
        reportMismatch({name, " moving before strobe"}, 1, int'(driveReq.moving));
      @(posedge clk);
      lineCross <= 1'b1;
      @(posedge clk);
      lineCross <= 1'b0;
      @(negedge clk);
      if (driveReq.moving !== (i < n - 1))
        reportMismatch({name, " moving after strobe"}, int'(i < n - 1), int'(driveReq.moving));
    end
  endtask

  task automatic waitMoving(input string name, output logic ok);
    int n;
    n = 0;
    @(negedge clk);
    while (driveReq.moving !== 1'b1 && n < respWait) begin
      @(negedge clk);
      n++;
    end
    ok = (driveReq.moving === 1'b1);
    if (!ok) begin
      failures++;
      $display("%s: moving never rose after the command", name);
    end
  endtask

  task automatic waitResp(input string name, output logic [7:0] b);
    int n;
    n = 0;
    b = 8'h00;
    while (respQ.size() == 0 && n < respWait) begin
      @(negedge clk);
      n++;
    end
    if (respQ.size() == 0) begin
      failures++;
      $display("%s: no response byte arrived within %0d cycles", name, respWait);
    end else
      b = respQ.pop_front();
  endtask

  //////////////////////////////
  // One command, end to end
  //////////////////////////////

  task automatic runCommand(input string name, input logic [3:0] op,
                            input logic [7:0] heading, input logic [3:0] squares);
    logic [7:0] resp;
    logic       ok;
    int         calBase, movingBase;
    calBase    = calCount;
    movingBase = movingCount;
    sendCmd({op, heading, squares});
    if (op == 4'h4)
      expHeading = heading;
    if (willMove(op, squares)) begin
      strays(1 + int'(randBits(2)));
      waitMoving(name, ok);
      if (ok) begin
        strobeLines(name, int'(squares));
        if (riseCycle - headCycle != `KNIGHT_SETTLE_CYCLES)
          reportMismatch({name, " settle cycles"}, `KNIGHT_SETTLE_CYCLES, riseCycle - headCycle);
      end
    end
    waitResp(name, resp);
    @(negedge clk);
    if (resp !== expectResp(op))
      reportMismatch({name, " response"}, int'(expectResp(op)), int'(resp));
    if (driveReq.heading !== expHeading)
      reportMismatch({name, " heading"}, int'(expHeading), int'(driveReq.heading));
    if (calCount - calBase != (op == 4'h2 ? `KNIGHT_CAL_CYCLES : 0))
      reportMismatch({name, " calibrating cycles"}, (op == 4'h2 ? `KNIGHT_CAL_CYCLES : 0),
                     calCount - calBase);
    if (!willMove(op, squares) && movingCount != movingBase)
      reportMismatch({name, " moving cycles"}, 0, movingCount - movingBase);
    // Zero squares is answered once settle ends and reaches tx two cycles later
    if (op == 4'h4 && squares == 4'd0 &&
        txFallCycle - headCycle != `KNIGHT_SETTLE_CYCLES + 2)
      reportMismatch({name, " response start"}, `KNIGHT_SETTLE_CYCLES + 2,
                     txFallCycle - headCycle);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : mainSeq
    logic [7:0] heading;
    logic [7:0] resp;
    logic [3:0] squares;
    logic [3:0] op;
    logic       ok;
    int         t;
    lfsr       = 16'd11;
    expHeading = 8'h00;
    rstN       = 1'b0;
    rx         = 1'b1;
    lineCross  = 1'b0;
    repeat (3) @(posedge clk);
    rstN <= 1'b1;

    // Idle after reset
    for (t = 0; t < 100; t++) begin
      @(negedge clk);
      if (tx !== 1'b1)
        reportMismatch("reset tx", 1, int'(tx));
      if (driveReq.moving !== 1'b0 || calibrating !== 1'b0)
        reportMismatch("reset moving calibrating", 0, int'({driveReq.moving, calibrating}));
      if (driveReq.heading !== 8'h00)
        reportMismatch("reset heading", 0, int'(driveReq.heading));
    end
    if (respQ.size() != 0) begin
      failures++;
      $display("reset: a response byte appeared without a command");
    end

    runCommand("cal", 4'h2, 8'(randBits(8)), 4'(randBits(4)));

    for (t = 0; t < moveTests; t++) begin
      heading = 8'(randBits(8));
      if (heading == expHeading)
        heading = ~heading;
      squares = 4'(1 + randBits(4) % 15);
      runCommand("move", 4'h4, heading, squares);
    end

    runCommand("zero", 4'h4, ~expHeading, 4'd0);

    // Random codes nudged off the two known opcodes
    for (t = 0; t < unknownTests; t++) begin
      op = 4'(randBits(4));
      if (op == 4'h2 || op == 4'h4)
        op = op ^ 4'h1;
      runCommand("unknown", op, 8'(randBits(8)), 4'(randBits(4)));
    end

    // Second command lands while the first is driving
    heading = ~expHeading;
    squares = 4'(1 + randBits(4) % 15);
    sendCmd({4'h4, heading, squares});
    expHeading = heading;
    waitMoving("busy", ok);
    if (ok) begin
      sendCmd({4'h4, ~heading, 4'd3});
      @(negedge clk);
      if (driveReq.heading !== expHeading)
        reportMismatch("busy heading in drive", int'(expHeading), int'(driveReq.heading));
      strobeLines("busy", int'(squares));
    end
    waitResp("busy", resp);
    if (resp !== 8'hA5)
      reportMismatch("busy response", 'hA5, int'(resp));
    repeat (2 * frameCycles) @(negedge clk);
    if (respQ.size() != 0) begin
      failures++;
      $display("busy: %0d extra response bytes arrived", respQ.size());
    end
    if (driveReq.heading !== expHeading)
      reportMismatch("busy heading", int'(expHeading), int'(driveReq.heading));

    $display("Summary: %0d mismatches, %0d other failures", mismatches,
             failures + frameErrors);
    if (mismatches == 0 && failures + frameErrors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- knight_settings.svh
`ifndef KNIGHT_SETTINGS_SVH
`define KNIGHT_SETTINGS_SVH

//////////////////////////////
// UART timing
//////////////////////////////

// Clock cycles per UART bit
// Small value for simulation; scale up for a real baud rate
`define KNIGHT_BAUD_DIV 16

//////////////////////////////
// Motion timing
//////////////////////////////

// Gyro calibration length in clock cycles
`define KNIGHT_CAL_CYCLES 200

// Cycles the heading is held before driving forward
`define KNIGHT_SETTLE_CYCLES 50

`endif

//--- remoteLink.sv
`timescale 1ns/100ps
`default_nettype none

module remoteLink (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic [7:0]                rxByte,
  input  logic                      rxByteRdy,
  output knightCmdPkg::knightCmd_t  cmd,
  output logic                      cmdRdy,
  input  knightCmdPkg::knightResp_e respByte,
  input  logic                      respSend,
  output logic [7:0]                txByte,
  output logic                      txStart,
  input  logic                      txBusy
);

  logic [7:0] highByte;
  logic       expectLow;

  //////////////////////////////
  // Command assembly
  //////////////////////////////

  // expectLow tracks which half comes next; reset waits for the high byte
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      expectLow <= 1'b0;
      cmdRdy    <= 1'b0;
    end else begin
      cmdRdy <= rxByteRdy && expectLow;
      if (rxByteRdy)
        expectLow <= !expectLow;
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (rxByteRdy && !expectLow)
      highByte <= rxByte;
    if (rxByteRdy && expectLow)
      cmd <= knightCmdPkg::knightCmd_t'({highByte, rxByte});
  end

  //////////////////////////////
  // Response path
  //////////////////////////////

  // Busy covers the frame; txStart covers the cycle before busy rises
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      txStart <= 1'b0;
    else
      txStart <= respSend && !txBusy && !txStart;
  end

  always_ff @(posedge clk)
    if (respSend)
      txByte <= respByte;

endmodule

`default_nettype wire

//--- uartRx.sv
`timescale 1ns/100ps
`default_nettype none
`include "knight_settings.svh"

module uartRx (
  input  logic       clk,
  input  logic       rstN,
  input  logic       rx,
  output logic [7:0] rxByte,
  output logic       rxByteRdy
);

  // Reload values for the bit timer
  localparam logic [7:0] bitLoad  = 8'(`KNIGHT_BAUD_DIV - 1);
  localparam logic [7:0] halfLoad = 8'(`KNIGHT_BAUD_DIV / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxState_e;

  rxState_e   state;
  logic       rxMeta, rxSync, rxPrev;
  logic [7:0] baudCnt;
  logic [2:0] bitCnt;
  logic [7:0] shiftReg;

  // Two-flop synchronizer plus one flop for edge detect
  // Line idles high, so all three reset to one
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      rxMeta <= 1'b1;
      rxSync <= 1'b1;
      rxPrev <= 1'b1;
    end else begin
      rxMeta <= rx;
      rxSync <= rxMeta;
      rxPrev <= rxSync;
    end
  end

  // Frame FSM, sampling at mid-bit when baudCnt hits zero
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state     <= RX_IDLE;
      baudCnt   <= '0;
      bitCnt    <= '0;
      rxByteRdy <= 1'b0;
    end else begin
      rxByteRdy <= 1'b0;
      if (state != RX_IDLE)
        baudCnt <= baudCnt - 8'd1;
      case (state)
        RX_IDLE: if (rxPrev && !rxSync) begin
          // Falling start edge, aim for the middle of the start bit
          state   <= RX_START;
          baudCnt <= halfLoad;
        end
        RX_START: if (baudCnt == '0) begin
          // Start bit gone high again means a glitch
          state   <= rxSync ? RX_IDLE : RX_DATA;
          baudCnt <= bitLoad;
          bitCnt  <= '0;
        end
        RX_DATA: if (baudCnt == '0) begin
          baudCnt <= bitLoad;
          bitCnt  <= bitCnt + 3'd1;
          if (bitCnt == 3'd7)
            state <= RX_STOP;
        end
        default: if (baudCnt == '0) begin
          // Bad stop bit drops the whole frame
          rxByteRdy <= rxSync;
          state     <= RX_IDLE;
        end
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge clk)
    if (state == RX_DATA && baudCnt == '0)
      shiftReg <= {rxSync, shiftReg[7:1]};

  assign rxByte = shiftReg;

endmodule

`default_nettype wire

//--- uartTx.sv
`timescale 1ns/100ps
`default_nettype none
`include "knight_settings.svh"

module uartTx (
  input  logic       clk,
  input  logic       rstN,
  input  logic       txStart,
  input  logic [7:0] txByte,
  output logic       tx,
  output logic       txBusy
);

  localparam logic [7:0] bitLoad = 8'(`KNIGHT_BAUD_DIV - 1);

  logic [9:0] frame;
  logic [7:0] baudCnt;
  logic [3:0] bitCnt;

  //////////////////////////////
  // Frame shifter
  //////////////////////////////

  // Frame is stop, data, start with the start bit in bit 0
  // Shifting in ones leaves the line idle high
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      frame   <= '1;
      baudCnt <= '0;
      bitCnt  <= '0;
      txBusy  <= 1'b0;
    end else if (txStart && !txBusy) begin
      frame   <= {1'b1, txByte, 1'b0};
      baudCnt <= bitLoad;
      bitCnt  <= '0;
      txBusy  <= 1'b1;
    end else if (txBusy) begin
      if (baudCnt != '0) begin
        baudCnt <= baudCnt - 8'd1;
      end else if (bitCnt == 4'd9) begin
        // End of stop bit
        txBusy <= 1'b0;
      end else begin
        frame   <= {1'b1, frame[9:1]};
        baudCnt <= bitLoad;
        bitCnt  <= bitCnt + 4'd1;
      end
    end
  end

  // Line straight from the shifter, no extra stage
  assign tx = frame[0];

endmodule

`default_nettype wire
